/* cmd_decoder.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module cmd_decoder (
  input  logic                              CLK,
  input  logic                              resetn,
  input  cmd_pkg::host_word_t               word_data_received,
  input  logic                              word_received,
  output cmd_pkg::host_word_t               word_send_data,
  input  motion_pkg::pos_t [`NUM_AXES-1:0]  positions,
  output logic                              move_commit,
  output motion_pkg::move_t                 new_move,
  output logic [`NUM_AXES-1:0]              enable,
  output logic [7:0]                        clk_divisor
);
  import cmd_pkg::*;
  import motion_pkg::*;

  // Header, duration, then two words per axis
  localparam int LAST_WORD = 2 * `NUM_AXES + 1;

  logic                  word_received_q;
  logic                  word_rise;
  cmd_header_t           hdr;
  logic [7:0]            msg_header;  // Code of the transfer in progress
  logic [7:0]            word_cnt;    // Index of the next word within it
  logic                  in_move;
  move_t                 move_asm;
  pos_t [`NUM_AXES-1:0]  pos_snap;    // Positions frozen at the move header

  // Sign extend a position into a reply word
  function automatic host_word_t pos_word(input pos_t p);
    return {{(64 - `POS_BITS){p[`POS_BITS-1]}}, p};
  endfunction

  assign hdr       = cmd_header_t'(word_data_received);
  assign word_rise = word_received & ~word_received_q;
  assign in_move   = (msg_header == CMD_COORDINATED_STEP);
  assign new_move  = move_asm;

  // Registers, word tracking and the reply
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      msg_header      <= 8'h00;
      word_cnt        <= 8'd0;
      move_commit     <= 1'b0;
      enable          <= '0;
      clk_divisor     <= 8'(`DEFAULT_CLK_DIVISOR);
      word_send_data  <= '0;
    end else begin
      word_received_q <= word_received;
      move_commit     <= 1'b0;

      if (word_rise) begin
        word_send_data <= '0;  // Zero unless a reply is set below

        if (!in_move) begin
          // Any word outside a move is a header
          msg_header <= hdr.code;
          word_cnt   <= 8'd1;

          case (hdr.code)
            CMD_MOTOR_ENABLE: enable <= hdr.arg[`NUM_AXES-1:0];
            CMD_CLK_DIVISOR:  clk_divisor <= hdr.arg[7:0];
            CMD_API_VERSION: begin
              word_send_data <= {32'h0, `API_MAJOR, `API_MINOR, `API_PATCH, `API_DEVEL};
            end
            default: ;  // Move header and unknown codes reply zero
          endcase
        end else begin
          word_cnt <= word_cnt + 8'd1;

          // Duration word returns axis 0 and incrementincrement of axis n-1 returns axis n
          for (int n = 0; n < `NUM_AXES; n++) begin
            if (word_cnt == 8'(2 * n + 1)) begin
              word_send_data <= pos_word(pos_snap[n]);
            end
          end

          if (word_cnt == 8'(LAST_WORD)) begin
            move_commit <= 1'b1;
            msg_header  <= 8'h00;  // Back to header decoding
            word_cnt    <= 8'd0;
          end
        end
      end
    end
  end

  // Move assembly across words
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!in_move) begin
        if (hdr.code == CMD_COORDINATED_STEP) begin
          move_asm.dir <= hdr.arg[`NUM_AXES-1:0];
          pos_snap     <= positions;
        end
      end else begin
        if (word_cnt == 8'd1) begin
          move_asm.duration <= word_data_received[`DURATION_BITS-1:0];
        end
        for (int n = 0; n < `NUM_AXES; n++) begin
          if (word_cnt == 8'(2 * n + 2)) begin
            move_asm.profile[n].increment <= word_data_received;
          end
          if (word_cnt == 8'(2 * n + 3)) begin
            move_asm.profile[n].incrementincrement <= word_data_received;
          end
        end
      end
    end
  end

endmodule

/* cmd_pkg.sv */
package cmd_pkg;

  // Raw word as it moves over the host port
  typedef logic [63:0] host_word_t;

  // Header command codes
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,  // Multi word move transfer
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_API_VERSION      = 8'hfe
  } cmd_code_t;

  // Header word layout
  typedef struct packed {
    logic [7:0]  code;   // Compared against cmd_code_t
    logic [7:0]  axis;   // Axis selector
    logic [47:0] arg;    // Command argument
  } cmd_header_t;

endpackage

/* dda_axis.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module dda_axis (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic                       dda_tick,
  input  logic                       load_move,
  input  logic                       executing,
  input  motion_pkg::axis_profile_t  profile,
  input  logic                       dir,
  output logic                       step,
  output motion_pkg::pos_t           position
);
  import motion_pkg::*;

  logic [63:0]    accum;
  logic [64:0]    acc_sum;  // Bit 64 is the carry that makes a step
  axis_profile_t  rate;     // Running velocity and fixed acceleration
  logic           advance;

  assign advance = executing & dda_tick;
  assign acc_sum = {1'b0, accum} + {1'b0, rate.increment};

  // Accumulator and velocity
  always_ff @(posedge CLK) begin
    if (load_move) begin
      accum <= '0;
      rate  <= profile;
    end else if (advance) begin
      accum          <= acc_sum[63:0];
      rate.increment <= rate.increment + rate.incrementincrement;  // Uses old velocity above
    end
  end

  // Step pulse and position
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= advance & acc_sum[64];
      if (advance && acc_sum[64]) begin
        if (dir) begin
          position <= position + pos_t'(1);
        end else begin
          position <= position - pos_t'(1);
        end
      end
    end
  end

endmodule

/* dda_sequencer.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module dda_sequencer (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic [7:0]                 clk_divisor,
  input  logic                       head_valid,
  input  logic [`DURATION_BITS-1:0]  duration,
  output logic                       dda_tick,
  output logic                       load_move,
  output logic                       executing,
  output logic                       release_slot,
  output logic                       move_done
);

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN, S_DONE} seq_state_t;

  seq_state_t                 state;
  logic [7:0]                 div_cnt;
  logic [`DURATION_BITS-1:0]  ticks_left;

  // Tick divider
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt  <= 8'd0;
      dda_tick <= 1'b0;
    end else if (div_cnt >= clk_divisor) begin  // Also catches a lowered divisor
      div_cnt  <= 8'd0;
      dda_tick <= 1'b1;
    end else begin
      div_cnt  <= div_cnt + 8'd1;
      dda_tick <= 1'b0;
    end
  end

  // Move execution over the head slot
  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= S_IDLE;
      ticks_left <= '0;
    end else begin
      case (state)
        S_IDLE: if (head_valid) state <= S_LOAD;
        S_LOAD: begin
          ticks_left <= duration;
          state      <= S_RUN;
        end
        S_RUN: begin
          if (dda_tick) begin
            if (ticks_left == `DURATION_BITS'(1)) state <= S_DONE;  // Last tick
            ticks_left <= ticks_left - `DURATION_BITS'(1);
          end
        end
        default: state <= S_IDLE;  // S_DONE lasts one cycle
      endcase
    end
  end

  assign load_move    = (state == S_LOAD);
  assign executing    = (state == S_RUN);
  assign move_done    = (state == S_DONE);
  assign release_slot = (state == S_DONE);

  // A zero duration would run until the counter wraps
  assert property (@(posedge CLK) disable iff (resetn)
    load_move |-> (duration != '0))
    else $error("dda_sequencer: move loaded with zero duration");

endmodule

/* motion_ctrl_top.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module motion_ctrl_top (
  input  logic                      CLK,
  input  logic                      resetn,
  input  cmd_pkg::host_word_t       word_data_received,
  input  logic                      word_received,
  output cmd_pkg::host_word_t       word_send_data,
  output logic                      buffer_dtr,
  output logic                      move_done,
  output motion_pkg::stepper_out_t  stepper
);
  import motion_pkg::*;

  move_t                 new_move;
  move_t                 head_move;
  pos_t [`NUM_AXES-1:0]  positions;
  logic                  move_commit;
  logic                  head_valid;
  logic                  release_slot;
  logic                  dda_tick;
  logic                  load_move;
  logic                  executing;
  logic [7:0]            clk_divisor;
  logic [`NUM_AXES-1:0]  enable;
  logic [`NUM_AXES-1:0]  step;

  assign stepper = '{step: step, dir: head_move.dir, enable: enable};

  cmd_decoder u_decoder (
    .CLK(CLK), .resetn(resetn),
    .word_data_received(word_data_received), .word_received(word_received),
    .word_send_data(word_send_data), .positions(positions),
    .move_commit(move_commit), .new_move(new_move),
    .enable(enable), .clk_divisor(clk_divisor)
  );

  move_buffer u_buffer (
    .CLK(CLK), .resetn(resetn),
    .move_commit(move_commit), .new_move(new_move), .release_slot(release_slot),
    .head_valid(head_valid), .head_move(head_move), .buffer_dtr(buffer_dtr)
  );

  dda_sequencer u_sequencer (
    .CLK(CLK), .resetn(resetn),
    .clk_divisor(clk_divisor), .head_valid(head_valid), .duration(head_move.duration),
    .dda_tick(dda_tick), .load_move(load_move), .executing(executing),
    .release_slot(release_slot), .move_done(move_done)
  );

  for (genvar i = 0; i < `NUM_AXES; i++) begin : g_axis
    dda_axis u_axis (
      .CLK(CLK), .resetn(resetn),
      .dda_tick(dda_tick), .load_move(load_move), .executing(executing),
      .profile(head_move.profile[i]), .dir(head_move.dir[i]),
      .step(step[i]), .position(positions[i])
    );
  end

endmodule

/* motion_params.svh */
`ifndef MOTION_PARAMS_SVH
`define MOTION_PARAMS_SVH

// Axis count and move buffer sizing
`define NUM_AXES            2
`define BUFFER_DEPTH        2   // Power of two only

// Field widths
`define DURATION_BITS       32  // Move length in DDA ticks
`define POS_BITS            32  // Signed step position per axis

// Tick divisor after reset giving a period of divisor+1 clocks
`define DEFAULT_CLK_DIVISOR 32

// Version bytes returned on the API version command
`define API_MAJOR           8'd1
`define API_MINOR           8'd2
`define API_PATCH           8'd0
`define API_DEVEL           8'd0

`endif

/* motion_pkg.sv */
`include "motion_params.svh"

package motion_pkg;

  // Signed step count of one axis
  typedef logic signed [`POS_BITS-1:0] pos_t;

  // Move buffer index
  typedef logic [$clog2(`BUFFER_DEPTH)-1:0] slot_idx_t;

  // Rate profile of one axis for one move
  typedef struct packed {
    logic signed [63:0] increment;           // Velocity added to the accumulator
    logic signed [63:0] incrementincrement;  // Acceleration added to the velocity
  } axis_profile_t;

  // One coordinated move as held in the buffer
  typedef struct packed {
    logic [`NUM_AXES-1:0]                 dir;       // High counts up
    logic [`DURATION_BITS-1:0]            duration;  // Length in DDA ticks
    axis_profile_t [`NUM_AXES-1:0]        profile;
  } move_t;

  // Pins toward the stepper drivers
  typedef struct packed {
    logic [`NUM_AXES-1:0] step;
    logic [`NUM_AXES-1:0] dir;
    logic [`NUM_AXES-1:0] enable;
  } stepper_out_t;

endpackage

/* move_buffer.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module move_buffer (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               move_commit,
  input  motion_pkg::move_t  new_move,
  input  logic               release_slot,
  output logic               head_valid,
  output motion_pkg::move_t  head_move,
  output logic               buffer_dtr
);
  import motion_pkg::*;

  move_t                     slots [`BUFFER_DEPTH];
  logic [`BUFFER_DEPTH-1:0]  slot_valid;
  slot_idx_t                 wr_idx;    // Next slot the decoder fills
  slot_idx_t                 head_idx;  // Slot the sequencer runs

  assign head_valid = slot_valid[head_idx];
  assign head_move  = slots[head_idx];
  assign buffer_dtr = ~slot_valid[wr_idx];  // Room for one more move

  // Move storage
  always_ff @(posedge CLK) begin
    if (move_commit) begin
      slots[wr_idx] <= new_move;
    end
  end

  // Valid bits and both indices
  always_ff @(posedge CLK) begin
    if (resetn) begin
      slot_valid <= '0;
      wr_idx     <= '0;
      head_idx   <= '0;
    end else begin
      if (move_commit) begin
        slot_valid[wr_idx] <= 1'b1;
        wr_idx             <= wr_idx + 1'b1;  // Wraps since the depth is a power of two
      end
      if (release_slot) begin
        slot_valid[head_idx] <= 1'b0;
        head_idx             <= head_idx + 1'b1;
      end
    end
  end

  // Host must wait for buffer_dtr before starting a move transfer
  assert property (@(posedge CLK) disable iff (resetn)
    move_commit |-> !slot_valid[wr_idx])
    else $error("move_buffer: commit into occupied slot %0d", wr_idx);

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_motion_ctrl -f src.f -o sim_motion_ctrl
out=$(./obj_dir/sim_motion_ctrl)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

/* src.f */
+incdir+.
cmd_pkg.sv
motion_pkg.sv
cmd_decoder.sv
move_buffer.sv
dda_sequencer.sv
dda_axis.sv
motion_ctrl_top.sv
tb_motion_ctrl.sv

/* tb_motion_ctrl.sv */
`timescale 1ns/1ps
`include "motion_params.svh"

module tb_motion_ctrl;
  import cmd_pkg::*;
  import motion_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int NEW_DIVISOR = 5;
  localparam int DUR_A       = 37;  // Also replayed after the divisor change
  localparam int DUR_B       = 25;
  localparam int DUR_C       = 30;
  localparam int DUR_D       = 20;
  localparam int MARGIN_NS   = 20000;
  localparam int WATCHDOG_NS = CLK_PERIOD * ((DUR_A + DUR_B + DUR_C + DUR_D)
                               * (`DEFAULT_CLK_DIVISOR + 1) + DUR_A * (NEW_DIVISOR + 1))
                               + MARGIN_NS;

  logic          CLK;
  logic          resetn;
  host_word_t    word_data_received;
  logic          word_received;
  host_word_t    word_send_data;
  logic          buffer_dtr;
  logic          move_done;
  stepper_out_t  stepper;

  logic [15:0]           lfsr_state;
  int                    step_total [`NUM_AXES];  // Step pulses seen per axis
  int                    done_total;
  int                    err_count;
  int                    checks_run;
  int                    tests_run;
  int                    tests_failed;
  int                    test_err_start;
  pos_t [`NUM_AXES-1:0]  model_pos;  // Expected axis positions
  move_t                 move_a;
  move_t                 move_b;
  move_t                 move_c;
  move_t                 move_d;

  motion_ctrl_top dut (
    .CLK(CLK), .resetn(resetn),
    .word_data_received(word_data_received), .word_received(word_received),
    .word_send_data(word_send_data), .buffer_dtr(buffer_dtr),
    .move_done(move_done), .stepper(stepper)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Step and move_done counters
  always @(posedge CLK) begin
    if (resetn) begin
      for (int a = 0; a < `NUM_AXES; a++) step_total[a] <= 0;
      done_total <= 0;
    end else begin
      for (int a = 0; a < `NUM_AXES; a++) begin
        if (stepper.step[a]) step_total[a] <= step_total[a] + 1;
      end
      if (move_done) done_total <= done_total + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // DDA rule per axis over the whole duration
  function automatic void model_move(input move_t m, input pos_t [`NUM_AXES-1:0] pos_in,
                                     output pos_t [`NUM_AXES-1:0] pos_out,
                                     output logic [`NUM_AXES-1:0][31:0] steps);
    logic [64:0] sum;
    logic [63:0] accum;
    logic [63:0] vel;
    pos_out = pos_in;
    for (int a = 0; a < `NUM_AXES; a++) begin
      accum    = '0;
      vel      = m.profile[a].increment;
      steps[a] = '0;
      for (int t = 0; t < int'(m.duration); t++) begin
        sum   = {1'b0, accum} + {1'b0, vel};
        accum = sum[63:0];
        if (sum[64]) begin  // Carry out is one step
          steps[a]   = steps[a] + 32'd1;
          pos_out[a] = m.dir[a] ? pos_out[a] + pos_t'(1) : pos_out[a] - pos_t'(1);
        end
        vel = vel + m.profile[a].incrementincrement;
      end
    end
  endfunction

  function automatic host_word_t header_word(input logic [7:0] code, input logic [47:0] arg);
    return {code, 8'h00, arg};
  endfunction

  // Major byte on top down to the devel byte in bits 7:0
  function automatic host_word_t version_word();
    host_word_t w;
    w        = '0;
    w[31:24] = `API_MAJOR;
    w[23:16] = `API_MINOR;
    w[15:8]  = `API_PATCH;
    w[7:0]   = `API_DEVEL;
    return w;
  endfunction

  task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
    checks_run++;
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_pos(input string name, input pos_t got, input pos_t exp);
    checks_run++;
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks_run++;
    if (got != exp) begin
      $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic begin_test();
    test_err_start = err_count;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (err_count == test_err_start) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL", tests_run, name);
    end
  endtask

  // Two cycles high, two low, then read the reply
  task automatic send_word(input host_word_t w, output host_word_t reply);
    @(posedge CLK);
    #2;
    word_data_received = w;
    word_received      = 1'b1;
    repeat (2) @(posedge CLK);
    #2;
    word_received = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    reply = word_send_data;
  endtask

  task automatic wait_dtr();
    int cycles;
    cycles = 0;
    while (!buffer_dtr && cycles < 200) begin
      @(negedge CLK);
      cycles++;
    end
    if (!buffer_dtr) begin
      $display("buffer_dtr stayed low for %0d cycles before a move transfer", cycles);
      err_count++;
    end
  endtask

  task automatic wait_moves(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (done_total < target && cycles < limit) begin
      @(negedge CLK);
      cycles++;
    end
    if (done_total < target) begin
      $display("Move did not finish within %0d cycles", limit);
      err_count++;
    end
  endtask

  task automatic make_move(input int dur, output move_t m);
    logic [63:0] bits;
    take_bits(`NUM_AXES, bits);
    m.dir      = bits[`NUM_AXES-1:0];
    m.duration = `DURATION_BITS'(dur);
    for (int a = 0; a < `NUM_AXES; a++) begin
      take_bits(64, bits);
      m.profile[a].increment = bits;
      take_bits(56, bits);
      m.profile[a].incrementincrement = {{8{bits[55]}}, bits[55:0]};
    end
  endtask

  // Odd words after the header return the position of axis (k-1)/2
  task automatic send_move(input move_t m, input bit check_positions);
    host_word_t words [2 * `NUM_AXES + 2];
    host_word_t reply;
    int         n;
    words[0] = header_word(CMD_COORDINATED_STEP, 48'(m.dir));
    words[1] = 64'(m.duration);
    for (int a = 0; a < `NUM_AXES; a++) begin
      words[2 + 2 * a] = m.profile[a].increment;
      words[3 + 2 * a] = m.profile[a].incrementincrement;
    end
    for (int k = 0; k < 2 * `NUM_AXES + 2; k++) begin
      send_word(words[k], reply);
      n = (k - 1) / 2;
      if (k % 2 == 1 && n < `NUM_AXES) begin
        if (check_positions) begin
          check_pos($sformatf("position reply axis %0d", n), pos_t'(reply[`POS_BITS-1:0]),
                    model_pos[n]);
        end
      end else begin
        check_word($sformatf("move reply word %0d", k), reply, '0);
      end
    end
  endtask

  task automatic play_move(input move_t m, input int divisor);
    int                          steps_start [`NUM_AXES];
    int                          done_start;
    pos_t [`NUM_AXES-1:0]        next_pos;
    logic [`NUM_AXES-1:0][31:0]  exp_steps;
    wait_dtr();
    for (int a = 0; a < `NUM_AXES; a++) steps_start[a] = step_total[a];
    done_start = done_total;
    send_move(m, 1'b1);
    @(negedge CLK);
    check_count("stepper.dir", int'(stepper.dir), int'(m.dir));
    wait_moves(done_start + 1, (int'(m.duration) + 2) * (divisor + 1) + 20);
    repeat (4) @(negedge CLK);  // Catches a stray extra move_done
    model_move(m, model_pos, next_pos, exp_steps);
    model_pos = next_pos;
    for (int a = 0; a < `NUM_AXES; a++) begin
      check_count($sformatf("step count axis %0d", a), step_total[a] - steps_start[a],
                  int'(exp_steps[a]));
    end
    check_count("move_done pulses", done_total - done_start, 1);
  endtask

  initial begin
    host_word_t                  reply;
    int                          steps_start [`NUM_AXES];
    int                          done_start;
    pos_t [`NUM_AXES-1:0]        pos_c;
    logic [`NUM_AXES-1:0][31:0]  steps_c;
    logic [`NUM_AXES-1:0][31:0]  steps_d;

    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    lfsr_state         = 16'd61596;
    model_pos          = '0;
    err_count          = 0;
    checks_run         = 0;
    tests_run          = 0;
    tests_failed       = 0;
    repeat (16) @(posedge CLK);
    #2;
    resetn = 1'b0;
    repeat (2) @(posedge CLK);

    begin_test();
    @(negedge CLK);
    check_count("buffer_dtr", int'(buffer_dtr), 1);
    check_count("stepper.enable", int'(stepper.enable), 0);
    send_word(header_word(CMD_API_VERSION, '0), reply);
    check_word("api version reply", reply, version_word());
    end_test("reset state and API version");

    begin_test();
    send_word(header_word(CMD_MOTOR_ENABLE, 48'(`NUM_AXES'(1))), reply);
    check_word("enable reply", reply, '0);
    check_count("stepper.enable", int'(stepper.enable), 1);
    send_word(header_word(8'h55, 48'hffff), reply);  // Not a known code
    check_word("unknown header reply", reply, '0);
    check_count("stepper.enable", int'(stepper.enable), 1);
    send_word(header_word(CMD_MOTOR_ENABLE, 48'({`NUM_AXES{1'b1}})), reply);
    check_count("stepper.enable", int'(stepper.enable), int'({`NUM_AXES{1'b1}}));
    end_test("enable register and unknown header");

    begin_test();
    make_move(DUR_A, move_a);
    play_move(move_a, `DEFAULT_CLK_DIVISOR);
    end_test("single move step counts");

    begin_test();
    make_move(DUR_B, move_b);
    play_move(move_b, `DEFAULT_CLK_DIVISOR);  // Replies carry positions after move A
    end_test("position replies");

    begin_test();
    make_move(DUR_C, move_c);
    make_move(DUR_D, move_d);
    wait_dtr();
    for (int a = 0; a < `NUM_AXES; a++) steps_start[a] = step_total[a];
    done_start = done_total;
    send_move(move_c, 1'b1);
    wait_dtr();
    send_move(move_d, 1'b0);  // Positions move while C runs
    @(negedge CLK);
    check_count("buffer_dtr after second commit", int'(buffer_dtr), 0);
    wait_moves(done_start + 2, (DUR_C + DUR_D + 4) * (`DEFAULT_CLK_DIVISOR + 1) + 40);
    repeat (4) @(negedge CLK);
    model_move(move_c, model_pos, pos_c, steps_c);
    model_move(move_d, pos_c, model_pos, steps_d);
    for (int a = 0; a < `NUM_AXES; a++) begin
      check_count($sformatf("step total axis %0d", a), step_total[a] - steps_start[a],
                  int'(steps_c[a]) + int'(steps_d[a]));
    end
    check_count("move_done pulses", done_total - done_start, 2);
    check_count("buffer_dtr after both moves", int'(buffer_dtr), 1);
    end_test("back to back moves");

    begin_test();
    send_word(header_word(CMD_CLK_DIVISOR, 48'(NEW_DIVISOR)), reply);
    check_word("divisor reply", reply, '0);
    play_move(move_a, NEW_DIVISOR);
    end_test("move after divisor change");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks_run, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
